// File: compile.f
+incdir+rtl
rtl/pcs_pkg.sv
rtl/enc_8b10b.sv
rtl/dec_8b10b.sv
rtl/pcs_tx.sv
rtl/pcs_rx.sv
rtl/negotiate.sv
rtl/gmii_link.sv
verification/gmii_link_asserts.sv
verification/gmii_link_tb.sv

// File: verification/gmii_link_testdata.txt
// loopback vectors for the gmii link testbench, hex words
// expected an_status, frame count, then each frame: length, bytes (bit 8 set = TX_ER)
0120
0005
// preamble only
0008 0055 0055 0055 0055 0055 0055 0055 00d5
// counting bytes
000c 0055 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b
// control values as data, fourth byte errored
000a 0055 00de 00ad 01be 00ef 0000 00ff 00bc 00fb 00fd
// short frame
0006 0055 00aa 0055 00f7 00fe 0080
// longer frame, ninth byte errored
0010 0055 0011 0022 0033 0044 0066 0077 0088
0133 0099 00bb 00cc 00dd 00ee 0010 0020

// File: verification/gmii_link_tb.sv
// gmii link testbench
// loopback negotiation, frames, loss of signal and bypass from a vector file
`default_nettype none
`include "gmii_link_defines.svh"

module gmii_link_tb
	import pcs_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic        GTX_CLK;
	logic        rst_n;
	logic [7:0]  TXD;
	logic        TX_EN;
	logic        TX_ER;
	code_group_t rxdata;
	logic        rx_err_los;
	logic        an_bypass;
	code_group_t txdata;
	logic [7:0]  RXD;
	logic        RX_DV;
	logic        RX_ER;
	logic        operate;
	lacr_t       lacr_rx;
	an_status_t  an_status;

	logic        line_silent;   // cut the loopback
	logic        rx_quiet;      // no frames on the line now
	logic [15:0] vec [0:255];   // vector file image
	int          frame_ptr [0:15];
	int          nframes = 0;
	int          total_bytes = 0;
	int          wd_limit = 0;
	an_status_t  exp_status;
	lacr_t       exp_lacr;      // own ability heard back with ack
	logic [31:0] lcg_state = 32'hd3a3_bb6d;
	logic [8:0]  exp_q [$];     // {er, byte} still to arrive
	int          mismatch_count = 0;
	int          fail_count = 0;

	gmii_link uut (
		.GTX_CLK    (GTX_CLK),
		.rst_n      (rst_n),
		.TXD        (TXD),
		.TX_EN      (TX_EN),
		.TX_ER      (TX_ER),
		.rxdata     (rxdata),
		.rx_err_los (rx_err_los),
		.an_bypass  (an_bypass),
		.txdata     (txdata),
		.RXD        (RXD),
		.RX_DV      (RX_DV),
		.RX_ER      (RX_ER),
		.operate    (operate),
		.lacr_rx    (lacr_rx),
		.an_status  (an_status)
	);

	assign rxdata = line_silent ? 10'h000 : txdata;   // loopback or dead line

	initial begin
		GTX_CLK = 1'b0;
		forever #4 GTX_CLK = ~GTX_CLK;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_cycle();
		@(posedge GTX_CLK);
		#1;
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] want, input string what);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is %02h, expected %02h", $time, what, got, want);
		end
	endtask

	task automatic check_flag(input logic got, input logic want, input string what);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic check_status(input an_status_t got, input an_status_t want, input string what);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is %03h, expected %03h", $time, what, got, want);
		end
	endtask

	task automatic check_lacr(input lacr_t got, input lacr_t want, input string what);
		if (got !== want) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s is %04h, expected %04h", $time, what, got, want);
		end
	endtask

	task automatic wait_for_operate(input int max_cycles, input string what);
		int n;
		n = 0;
		while (operate !== 1'b1 && n < max_cycles) begin
			next_cycle();
			n++;
		end
		if (operate !== 1'b1) begin
			fail_count++;
			$display("%s: link did not come up within %0d clocks", what, max_cycles);
		end
	endtask

	// link up in loopback means we heard our own ability with ack
	task automatic link_up_checks(input string what);
		wait_for_operate(`LINK_TIMER_TICKS + 200, what);
		check_lacr(lacr_rx, exp_lacr, {what, " lacr_rx"});
		check_status(an_status, exp_status, {what, " an_status"});
		repeat (8) next_cycle();
	endtask

	task automatic send_all_frames();
		int base;
		int len;
		int gap;
		logic [15:0] w;
		for (int f = 0; f < nframes; f++) begin
			base = frame_ptr[f];
			len  = int'(vec[base]);
			exp_q.push_back(9'h055);   // /S/ comes back as preamble
			for (int i = 2; i <= len; i++)
				exp_q.push_back(vec[base + i][8:0]);
			for (int i = 1; i <= len; i++) begin
				w     = vec[base + i];
				TXD   = w[7:0];
				TX_ER = w[8];
				TX_EN = 1'b1;
				next_cycle();
			end
			lcg_state = lcg_next(lcg_state);
			gap = 6 + int'(lcg_state[17:16]);   // room for /T/ /R/ and realign
			for (int g = 0; g < gap; g++) begin
				lcg_state = lcg_next(lcg_state);
				TXD   = lcg_state[31:24];   // filler bytes ignored while TX_EN is low
				TX_EN = 1'b0;
				TX_ER = 1'b0;
				next_cycle();
			end
		end
	endtask

	task automatic wait_rx_drain(input int max_cycles);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || RX_DV === 1'b1) && n < max_cycles) begin
			next_cycle();
			n++;
		end
		if (exp_q.size() != 0) begin
			fail_count++;
			$display("receive path left %0d frame bytes undelivered", exp_q.size());
			exp_q.delete();
		end
	endtask

	// receive side sampled mid cycle
	initial begin
		logic [8:0] exp_word;
		forever begin
			@(negedge GTX_CLK);
			if (RX_DV === 1'b1) begin
				if (rx_quiet) begin
					fail_count++;
					$display("RX_DV high at %0t while only idles and config were sent", $time);
				end else if (exp_q.size() == 0) begin
					fail_count++;
					$display("RX_DV high at %0t with no frame byte pending", $time);
				end else begin
					exp_word = exp_q.pop_front();
					check_flag(RX_ER, exp_word[8], "RX_ER");
					if (!exp_word[8])
						check_byte(RXD, exp_word[7:0], "RXD");   // data of /V/ is don't care
				end
			end
		end
	end

	initial begin
		wait (wd_limit > 0);
		repeat (wd_limit) @(posedge GTX_CLK);
		$display("watchdog expired after %0d clocks, test sequence stalled", wd_limit);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count + 1);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int idx;
		rst_n       = 1'b0;
		TXD         = 8'h00;
		TX_EN       = 1'b0;
		TX_ER       = 1'b0;
		rx_err_los  = 1'b0;
		an_bypass   = 1'b0;
		line_silent = 1'b1;   // txdata unknown until the first edge
		rx_quiet    = 1'b0;

		$readmemh("verification/gmii_link_testdata.txt", vec);
		if ($isunknown(vec[1])) begin
			fail_count++;
			$display("test data file could not be read, no frames to send");
		end else begin
			nframes = (int'(vec[1]) > 16) ? 16 : int'(vec[1]);
			idx = 2;
			for (int f = 0; f < nframes; f++) begin
				frame_ptr[f] = idx;
				total_bytes += int'(vec[idx]);
				idx += int'(vec[idx]) + 1;
			end
		end
		exp_status = an_status_t'(vec[0][8:0]);
		exp_lacr   = `AN_ABILITY;
		exp_lacr[`AN_ACK_BIT] = 1'b1;
		// two negotiations, two passes over the frames
		wd_limit = 2 * `LINK_TIMER_TICKS + 2 * total_bytes * 4 + 500;

		next_cycle();
		line_silent = 1'b0;
		repeat (3) next_cycle();
		rst_n    = 1'b1;
		rx_quiet = 1'b1;
		next_cycle();
		next_cycle();
		check_flag(operate, 1'b0, "operate after reset");
		check_status(an_status, '0, "an_status after reset");

		link_up_checks("first negotiation");

		rx_quiet = 1'b0;
		send_all_frames();
		wait_rx_drain(100);
		rx_quiet = 1'b1;

		// loss of signal restarts negotiation
		line_silent = 1'b1;
		rx_err_los  = 1'b1;
		next_cycle();
		next_cycle();
		check_flag(operate, 1'b0, "operate during los");
		check_status(an_status, '0, "an_status during los");
		repeat (16) next_cycle();
		line_silent = 1'b0;
		rx_err_los  = 1'b0;
		link_up_checks("after loss of signal");

		// bypass with no /C/ on the line still passes frames
		an_bypass = 1'b1;
		repeat (8) next_cycle();
		line_silent = 1'b1;
		rx_err_los  = 1'b1;
		repeat (4) next_cycle();
		line_silent = 1'b0;
		rx_err_los  = 1'b0;
		repeat (20) next_cycle();   // let rx disparity settle on idles
		check_flag(operate, 1'b0, "operate in bypass");
		check_status(an_status, '0, "an_status in bypass");
		rx_quiet = 1'b0;
		send_all_frames();
		wait_rx_drain(100);
		check_lacr(lacr_rx, exp_lacr, "lacr_rx in bypass");
		check_flag(operate, 1'b0, "operate after bypass frames");

		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count + fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/gmii_link_asserts.sv
// gmii link assertions
// reset behaviour of operate, RX_ER qualification, tx run length
`default_nettype none

module gmii_link_asserts
	import pcs_pkg::*;
(
	input logic        GTX_CLK,
	input logic        rst_n,
	input logic        operate,
	input logic        RX_DV,
	input logic        RX_ER,
	input code_group_t txdata
);

	timeunit 1ns;
	timeprecision 100ps;

	// six equal bits anywhere in two code groups
	function automatic logic run_over_five(input logic [19:0] bits);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i <= 14; i++)
			if (bits[i +: 6] == 6'b000000 || bits[i +: 6] == 6'b111111)
				hit = 1'b1;
		return hit;
	endfunction

	a_operate_reset: assert property (@(posedge GTX_CLK) !rst_n |=> !operate ##1 !operate)
		else $error("operate high in or right after reset");

	// no carrier extension from this pcs, so RX_ER always needs RX_DV
	a_rx_er_dv: assert property (@(posedge GTX_CLK) disable iff (!rst_n) RX_ER |-> RX_DV)
		else $error("RX_ER high without RX_DV");

	a_run_length: assert property (@(posedge GTX_CLK) disable iff (!rst_n)
		!run_over_five({$past(txdata), txdata}))
		else $error("txdata has a run of six equal bits");

endmodule

bind gmii_link gmii_link_asserts u_asserts (.*);

`default_nettype wire

// File: rtl/gmii_link.sv
// 1000BASE-X pcs, PHY side of GMII
// tx and rx pcs, 8b/10b codecs and negotiation on one clock
`default_nettype none

module gmii_link
	import pcs_pkg::*;
(
	input  logic        GTX_CLK,
	input  logic        rst_n,
	input  logic [7:0]  TXD,
	input  logic        TX_EN,
	input  logic        TX_ER,
	input  code_group_t rxdata,
	input  logic        rx_err_los,
	input  logic        an_bypass,   // skip config sets, send frames anyway
	output code_group_t txdata,
	output logic [7:0]  RXD,
	output logic        RX_DV,
	output logic        RX_ER,
	output logic        operate,
	output lacr_t       lacr_rx,
	output an_status_t  an_status
);

	symbol_t     tx_sym;
	code_group_t enc_code;
	logic        enc_disp;      // tx running disparity
	logic        enc_disp_out;
	symbol_t     dec_sym;
	symbol_t     dec_sym_q;
	logic        dec_disp;      // rx running disparity
	logic        dec_disp_out;
	logic        code_err;
	logic        disp_err;
	logic        code_err_q;
	logic        disp_err_q;
	lacr_t       lacr_out;
	logic        lacr_send;
	logic        lacr_rx_stb;

	pcs_tx u_pcs_tx (
		.GTX_CLK  (GTX_CLK),
		.rst_n    (rst_n),
		.tx_data  (TXD),
		.tx_en    (TX_EN & (operate | an_bypass)),   // hold frames until link up
		.tx_er    (TX_ER),
		.lacr_val (lacr_out),
		.lacr_en  (lacr_send & ~an_bypass),
		.tx_sym   (tx_sym)
	);

	enc_8b10b u_enc (.sym(tx_sym), .disp_in(enc_disp), .code(enc_code), .disp_out(enc_disp_out));

	dec_8b10b u_dec (
		.code     (rxdata),
		.disp_in  (dec_disp),
		.sym      (dec_sym),
		.disp_out (dec_disp_out),
		.code_err (code_err),
		.disp_err (disp_err)
	);

	always_ff @(posedge GTX_CLK) begin
		txdata    <= enc_code;
		dec_sym_q <= dec_sym;
		if (!rst_n) begin
			enc_disp   <= 1'b0;   // start negative
			dec_disp   <= 1'b0;
			code_err_q <= 1'b0;
			disp_err_q <= 1'b0;
		end else begin
			enc_disp   <= enc_disp_out;
			dec_disp   <= dec_disp_out;
			code_err_q <= code_err;
			disp_err_q <= disp_err;
		end
	end

	pcs_rx u_pcs_rx (
		.GTX_CLK      (GTX_CLK),
		.rst_n        (rst_n),
		.dec_sym      (dec_sym_q),
		.dec_err_code (code_err_q),
		.dec_err_disp (disp_err_q),
		.dec_err_los  (rx_err_los),
		.gmii_data    (RXD),
		.gmii_dv      (RX_DV),
		.gmii_err     (RX_ER),
		.lacr_rx_stb  (lacr_rx_stb),
		.lacr_rx_val  (lacr_rx)
	);

	negotiate u_negotiate (
		.GTX_CLK     (GTX_CLK),
		.rst_n       (rst_n),
		.los         (rx_err_los),
		.lacr_in     (lacr_rx),
		.lacr_in_stb (lacr_rx_stb),
		.lacr_out    (lacr_out),
		.lacr_send   (lacr_send),
		.operate     (operate),
		.an_status   (an_status)
	);

endmodule

`default_nettype wire

// File: rtl/negotiate.sv
// auto-negotiation
// ability exchange, ack, link timer, then operate
`default_nettype none
`include "gmii_link_defines.svh"

module negotiate
	import pcs_pkg::*;
#(
	parameter int TIMER_TICKS = `LINK_TIMER_TICKS
) (
	input  logic       GTX_CLK,
	input  logic       rst_n,
	input  logic       los,
	input  lacr_t      lacr_in,
	input  logic       lacr_in_stb,
	output lacr_t      lacr_out,
	output logic       lacr_send,
	output logic       operate,
	output an_status_t an_status
);

	localparam int TW = $clog2(TIMER_TICKS + 1);

	typedef enum logic [1:0] {AN_SEND, AN_ACK, AN_LINK, AN_UP} an_state_t;

	an_state_t   state;
	lacr_t       last_rx;
	logic [1:0]  match_cnt;   // identical words so far
	logic [TW-1:0] timer;
	logic        rx_zero;
	logic        rx_same;

	assign rx_zero  = lacr_in_stb && (lacr_in == '0);
	assign rx_same  = (lacr_in == last_rx) && (match_cnt != 2'd0) &&
		(state == AN_SEND || lacr_in[`AN_ACK_BIT]);
	assign lacr_out = (state == AN_SEND) ? `AN_ABILITY :
		(`AN_ABILITY | (16'd1 << `AN_ACK_BIT));

	always_ff @(posedge GTX_CLK) begin
		if (lacr_in_stb)
			last_rx <= lacr_in;
		if (!rst_n) begin
			state     <= AN_SEND;
			match_cnt <= 2'd0;
			timer     <= '0;
			lacr_send <= 1'b0;
			operate   <= 1'b0;
			an_status <= '0;
		end else if (los || rx_zero) begin   // restart
			state     <= AN_SEND;
			match_cnt <= 2'd0;
			timer     <= '0;
			lacr_send <= 1'b1;
			operate   <= 1'b0;
			an_status <= '0;
		end else begin
			case (state)
				AN_SEND, AN_ACK: begin
					lacr_send <= 1'b1;
					if (lacr_in_stb) begin
						if (!rx_same)
							match_cnt <= 2'd1;
						else if (match_cnt == 2'd2) begin   // third in a row
							match_cnt <= 2'd0;
							state     <= (state == AN_SEND) ? AN_ACK : AN_LINK;
						end else
							match_cnt <= match_cnt + 2'd1;
					end
				end
				AN_LINK: begin
					if (timer == TW'(TIMER_TICKS - 1)) begin
						state     <= AN_UP;
						lacr_send <= 1'b0;
						operate   <= 1'b1;
						an_status <= '{complete: 1'b1, ability: last_rx[7:0]};
					end else
						timer <= timer + 1'b1;
				end
				default: lacr_send <= 1'b0;   // link up, idles only
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/pcs_rx.sv
// pcs receive
// decoded symbols back to GMII bytes, config words out as a strobe
`default_nettype none
`include "gmii_link_defines.svh"

module pcs_rx
	import pcs_pkg::*;
(
	input  logic       GTX_CLK,
	input  logic       rst_n,
	input  symbol_t    dec_sym,
	input  logic       dec_err_code,
	input  logic       dec_err_disp,
	input  logic       dec_err_los,
	output logic [7:0] gmii_data,
	output logic       gmii_dv,
	output logic       gmii_err,
	output logic       lacr_rx_stb,
	output lacr_t      lacr_rx_val
);

	logic       bad;
	logic       in_frame;
	logic [1:0] cfg_pos;   // place inside a /C/ set
	logic [7:0] cfg_lo;
	logic [7:0] p_data;    // parser stage
	logic       p_dv;
	logic       p_err;

	assign bad = dec_err_code || dec_err_disp;

	always_ff @(posedge GTX_CLK) begin
		gmii_data <= p_data;
		if (!rst_n) begin
			in_frame    <= 1'b0;
			cfg_pos     <= 2'd0;
			p_dv        <= 1'b0;
			p_err       <= 1'b0;
			gmii_dv     <= 1'b0;
			gmii_err    <= 1'b0;
			lacr_rx_stb <= 1'b0;
		end else begin
			gmii_dv     <= p_dv;
			gmii_err    <= p_err;
			lacr_rx_stb <= 1'b0;
			p_err       <= 1'b0;
			if (dec_err_los) begin   // no light, hold idle
				in_frame <= 1'b0;
				cfg_pos  <= 2'd0;
				p_dv     <= 1'b0;
			end else if (!bad && dec_sym == {1'b1, `K27_7}) begin
				in_frame <= 1'b1;
				cfg_pos  <= 2'd0;
				p_data   <= 8'h55;   // preamble back in place of /S/
				p_dv     <= 1'b1;
			end else if (in_frame) begin
				if (dec_sym.k && (dec_sym.d == `K29_7 || dec_sym.d == `K28_5)) begin
					in_frame <= 1'b0;
					p_dv     <= 1'b0;
				end else begin
					p_data <= dec_sym.d;
					p_dv   <= 1'b1;
					p_err  <= bad || dec_sym.k;   // /V/ and junk
				end
			end else begin
				p_dv <= 1'b0;
				if (bad) begin
					cfg_pos <= 2'd0;
				end else begin
					case (cfg_pos)
						2'd0: if (dec_sym == {1'b1, `K28_5}) cfg_pos <= 2'd1;
						2'd1: begin
							if (!dec_sym.k && (dec_sym.d == `D21_5 || dec_sym.d == `D2_2))
								cfg_pos <= 2'd2;
							else
								cfg_pos <= 2'd0;   // /I2/ or noise
						end
						2'd2: begin
							cfg_lo  <= dec_sym.d;
							cfg_pos <= dec_sym.k ? 2'd0 : 2'd3;
						end
						default: begin
							cfg_pos <= 2'd0;
							if (!dec_sym.k) begin
								lacr_rx_val <= {dec_sym.d, cfg_lo};
								lacr_rx_stb <= 1'b1;
							end
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/pcs_tx.sv
// pcs transmit
// GMII bytes to ordered sets: /I2/, /C1/ /C2/, /S/ data /T/ /R/
`default_nettype none
`include "gmii_link_defines.svh"

module pcs_tx
	import pcs_pkg::*;
(
	input  logic       GTX_CLK,
	input  logic       rst_n,
	input  logic [7:0] tx_data,
	input  logic       tx_en,
	input  logic       tx_er,
	input  lacr_t      lacr_val,
	input  logic       lacr_en,
	output symbol_t    tx_sym
);

	typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_TERM, ST_EXT} tx_state_t;

	tx_state_t  state;
	logic       odd;        // parity of the slot being built
	logic       cfg_half;   // second pair of a /C/ set
	logic       cfg_c2;     // alternate /C1/ and /C2/
	logic       defer;      // frame pushed back one slot
	logic [7:0] hold_data;
	logic       hold_en;
	logic       hold_er;
	logic [7:0] cur_data;
	logic       cur_en;
	logic       cur_er;
	logic       extend;

	function automatic symbol_t ks(input logic [7:0] v);
		return {1'b1, v};
	endfunction

	function automatic symbol_t ds(input logic [7:0] v);
		return {1'b0, v};
	endfunction

	// deferred frames run one byte late through the hold register
	assign cur_data = defer ? hold_data : tx_data;
	assign cur_en   = defer ? hold_en : tx_en;
	assign cur_er   = defer ? hold_er : tx_er;
	assign extend   = cur_er && !cur_en;

	always_ff @(posedge GTX_CLK) begin
		hold_data <= tx_data;
		if (!rst_n) begin
			state    <= ST_IDLE;
			odd      <= 1'b0;
			cfg_half <= 1'b0;
			cfg_c2   <= 1'b0;
			defer    <= 1'b0;
			hold_en  <= 1'b0;
			hold_er  <= 1'b0;
			tx_sym   <= ds(`D16_2);
		end else begin
			odd     <= ~odd;
			hold_en <= tx_en;
			hold_er <= tx_er;
			case (state)
				ST_IDLE: begin
					if (cur_en && !odd) begin
						tx_sym   <= ks(`K27_7);   // /S/ eats the first byte
						cfg_half <= 1'b0;
						state    <= ST_DATA;
					end else begin
						if (cur_en)
							defer <= 1'b1;   // odd slot, wait one
						case ({odd, cfg_half})
							2'b00: tx_sym <= ks(`K28_5);
							2'b10: begin
								if (lacr_en)
									tx_sym <= ds(cfg_c2 ? `D2_2 : `D21_5);
								else
									tx_sym <= ds(`D16_2);
								cfg_half <= lacr_en;
							end
							2'b01: tx_sym <= ds(lacr_val[7:0]);
							default: begin
								tx_sym   <= ds(lacr_val[15:8]);
								cfg_half <= 1'b0;
								cfg_c2   <= ~cfg_c2;
							end
						endcase
					end
				end
				ST_DATA: begin
					if (cur_en) begin
						tx_sym <= cur_er ? ks(`K30_7) : ds(cur_data);
					end else begin
						tx_sym <= ks(`K29_7);   // /T/
						state  <= ST_TERM;
					end
				end
				ST_TERM: begin
					tx_sym <= ks(`K23_7);
					if (extend) begin
						state <= ST_EXT;
					end else if (odd) begin   // /R/ landed odd, aligned
						state <= ST_IDLE;
						defer <= 1'b0;
					end
				end
				default: begin
					tx_sym <= ks(`K23_7);   // carrier extend
					if (!extend && odd) begin
						state <= ST_IDLE;
						defer <= 1'b0;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/dec_8b10b.sv
// 8b/10b decoder
// inverse lookup with code group and running disparity checks
`default_nettype none

module dec_8b10b
	import pcs_pkg::*;
(
	input  code_group_t code,
	input  logic        disp_in,
	output symbol_t     sym,
	output logic        disp_out,
	output logic        code_err,   // not in table
	output logic        disp_err    // wrong polarity for rd
);

	logic [5:0] c6;
	logic [3:0] c4;
	logic [3:0] c4f;   // K28 rd+ balanced forms come inverted
	logic [4:0] x;
	logic [2:0] y;
	logic       ok6;
	logic       ok4;
	logic       k6;
	logic       alt;
	logic       alt_x;
	logic [2:0] n6;
	logic [2:0] n4;
	logic       rd_mid;

	always_comb begin
		c6  = code[9:4];
		c4  = code[3:0];
		ok6 = 1'b1;
		k6  = 1'b0;
		case (c6)
			6'b100111, 6'b011000: x = 5'd0;
			6'b011101, 6'b100010: x = 5'd1;
			6'b101101, 6'b010010: x = 5'd2;
			6'b110001:            x = 5'd3;
			6'b110101, 6'b001010: x = 5'd4;
			6'b101001:            x = 5'd5;
			6'b011001:            x = 5'd6;
			6'b111000, 6'b000111: x = 5'd7;
			6'b111001, 6'b000110: x = 5'd8;
			6'b100101:            x = 5'd9;
			6'b010101:            x = 5'd10;
			6'b110100:            x = 5'd11;
			6'b001101:            x = 5'd12;
			6'b101100:            x = 5'd13;
			6'b011100:            x = 5'd14;
			6'b010111, 6'b101000: x = 5'd15;
			6'b011011, 6'b100100: x = 5'd16;
			6'b100011:            x = 5'd17;
			6'b010011:            x = 5'd18;
			6'b110010:            x = 5'd19;
			6'b001011:            x = 5'd20;
			6'b101010:            x = 5'd21;
			6'b011010:            x = 5'd22;
			6'b111010, 6'b000101: x = 5'd23;
			6'b110011, 6'b001100: x = 5'd24;
			6'b100110:            x = 5'd25;
			6'b010110:            x = 5'd26;
			6'b110110, 6'b001001: x = 5'd27;
			6'b001110:            x = 5'd28;
			6'b101110, 6'b010001: x = 5'd29;
			6'b011110, 6'b100001: x = 5'd30;
			6'b101011, 6'b010100: x = 5'd31;
			6'b001111, 6'b110000: begin
				x  = 5'd28;
				k6 = 1'b1;
			end
			default: begin
				x   = 5'd0;
				ok6 = 1'b0;
			end
		endcase

		c4f = (k6 && c6[5]) ? ~c4 : c4;
		ok4 = 1'b1;
		alt = 1'b0;
		case (c4f)
			4'b1011, 4'b0100: y = 3'd0;
			4'b1001:          y = 3'd1;
			4'b0101:          y = 3'd2;
			4'b1100, 4'b0011: y = 3'd3;
			4'b1101, 4'b0010: y = 3'd4;
			4'b1010:          y = 3'd5;
			4'b0110:          y = 3'd6;
			4'b1110, 4'b0001: y = 3'd7;
			4'b0111, 4'b1000: begin
				y   = 3'd7;
				alt = 1'b1;
			end
			default: begin
				y   = 3'd0;
				ok4 = 1'b0;
			end
		endcase

		// K23/27/29/30.7 ride on the alternate x.7
		alt_x = (x == 5'd23 || x == 5'd27 || x == 5'd29 || x == 5'd30);
		sym.k = k6 || (alt && alt_x);
		sym.d = {y, x};
		code_err = !ok6 || !ok4 || (alt && !k6 && !alt_x && !(x == 5'd11 ||
			x == 5'd13 || x == 5'd14 || x == 5'd17 || x == 5'd18 || x == 5'd20));

		n6 = 3'($countones(c6));
		n4 = 3'($countones(c4));
		rd_mid   = (n6 == 3'd3) ? disp_in : (n6 > 3'd3);
		disp_err = (n6 == 3'd4 && disp_in) || (n6 == 3'd2 && !disp_in) ||
			(c6 == 6'b111000 && disp_in) || (c6 == 6'b000111 && !disp_in) ||
			(n4 == 3'd3 && rd_mid) || (n4 == 3'd1 && !rd_mid) ||
			(c4 == 4'b1100 && rd_mid) || (c4 == 4'b0011 && !rd_mid);
		disp_out = (n4 == 3'd2) ? rd_mid : (n4 > 3'd2);
	end

endmodule

`default_nettype wire

// File: rtl/enc_8b10b.sv
// 8b/10b encoder
// combinational, running disparity in and out
`default_nettype none

module enc_8b10b
	import pcs_pkg::*;
(
	input  symbol_t     sym,
	input  logic        disp_in,    // 1 = positive
	output code_group_t code,
	output logic        disp_out
);

	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] c6;    // rd- form
	logic [3:0] c4;    // rd- form
	logic [5:0] o6;
	logic [3:0] o4;
	logic       k28;
	logic       bal6;
	logic       bal4;
	logic       rd_mid;
	logic       alt7;

	assign x   = sym.d[4:0];
	assign y   = sym.d[7:5];
	assign k28 = sym.k && (x == 5'd28);

	always_comb begin
		case (x)
			5'd0:  c6 = 6'b100111;
			5'd1:  c6 = 6'b011101;
			5'd2:  c6 = 6'b101101;
			5'd3:  c6 = 6'b110001;
			5'd4:  c6 = 6'b110101;
			5'd5:  c6 = 6'b101001;
			5'd6:  c6 = 6'b011001;
			5'd7:  c6 = 6'b111000;
			5'd8:  c6 = 6'b111001;
			5'd9:  c6 = 6'b100101;
			5'd10: c6 = 6'b010101;
			5'd11: c6 = 6'b110100;
			5'd12: c6 = 6'b001101;
			5'd13: c6 = 6'b101100;
			5'd14: c6 = 6'b011100;
			5'd15: c6 = 6'b010111;
			5'd16: c6 = 6'b011011;
			5'd17: c6 = 6'b100011;
			5'd18: c6 = 6'b010011;
			5'd19: c6 = 6'b110010;
			5'd20: c6 = 6'b001011;
			5'd21: c6 = 6'b101010;
			5'd22: c6 = 6'b011010;
			5'd23: c6 = 6'b111010;
			5'd24: c6 = 6'b110011;
			5'd25: c6 = 6'b100110;
			5'd26: c6 = 6'b010110;
			5'd27: c6 = 6'b110110;
			5'd28: c6 = k28 ? 6'b001111 : 6'b001110;
			5'd29: c6 = 6'b101110;
			5'd30: c6 = 6'b011110;
			default: c6 = 6'b101011;
		endcase
		bal6 = ($countones(c6) == 3);
		// unbalanced and D.7 flip with rd
		o6     = ((!bal6 || x == 5'd7) && disp_in) ? ~c6 : c6;
		rd_mid = bal6 ? disp_in : ~disp_in;

		// alternate x.7 avoids a run of five
		alt7 = sym.k || (!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
			(rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14));
		case (y)
			3'd0: c4 = 4'b1011;
			3'd1: c4 = 4'b1001;
			3'd2: c4 = 4'b0101;
			3'd3: c4 = 4'b1100;
			3'd4: c4 = 4'b1101;
			3'd5: c4 = 4'b1010;
			3'd6: c4 = 4'b0110;
			default: c4 = alt7 ? 4'b0111 : 4'b1110;
		endcase
		bal4 = ($countones(c4) == 2);
		if (!bal4 || y == 3'd3)
			o4 = rd_mid ? ~c4 : c4;
		else if (k28)
			o4 = rd_mid ? c4 : ~c4;   // K28.1/2/5/6 invert the balanced form
		else
			o4 = c4;
		disp_out = bal4 ? rd_mid : ~rd_mid;
		code     = {o6, o4};
	end

endmodule

`default_nettype wire

// File: rtl/pcs_pkg.sv
// pcs types
// symbols, code groups, config words and negotiation status
`default_nettype none

package pcs_pkg;

	// one symbol before the encoder
	typedef struct packed {
		logic       k;   // control symbol
		logic [7:0] d;   // HGFEDCBA
	} symbol_t;

	// abcdei fghj, a in bit 9
	typedef logic [9:0] code_group_t;

	// clause-37 style config word
	typedef logic [15:0] lacr_t;

	// negotiation result
	typedef struct packed {
		logic       complete;
		logic [7:0] ability;   // partner low byte
	} an_status_t;

endpackage

`default_nettype wire

// File: rtl/gmii_link_defines.svh
// gmii link constants
// code-group byte values, negotiation timer length and local ability word
`ifndef GMII_LINK_DEFINES_SVH
`define GMII_LINK_DEFINES_SVH

// special symbols, K flag set
`define K28_5 8'hbc   // comma
`define K27_7 8'hfb   // /S/ start of packet
`define K29_7 8'hfd   // /T/ end of packet
`define K23_7 8'hf7   // /R/ carrier extend
`define K30_7 8'hfe   // /V/ error propagation

// second symbol of the two-symbol ordered sets
`define D21_5 8'hb5   // /C1/
`define D2_2  8'h42   // /C2/
`define D16_2 8'h50   // /I2/

// clocks of settle time before link up, short for sim
`define LINK_TIMER_TICKS 64

// full duplex only, no pause, ack clear
`define AN_ABILITY 16'h0020
`define AN_ACK_BIT 14

`endif
